// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := decompose_tb
FILELIST  := all.f

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

// ==== all.f ====
src/abr_params_pkg.sv
src/decompose_defines_pkg.sv
src/decompose_ctrl.sv
src/dcmp_feed.sv
src/decompose_lane.sv
src/dcmp_collect.sv
src/decompose_top.sv
verif/decompose_assertions.sv
verif/decompose_tb.sv

// ==== src/abr_params_pkg.sv ====
package abr_params_pkg;

    // --------------------
    // Memory geometry
    // --------------------

    // Word address into the shared polynomial memory
    localparam int ABR_MEM_ADDR_WIDTH = 15;

    // One word carries four 24-bit coefficient slots
    localparam int ABR_MEM_DATA_WIDTH = 96;

    // --------------------
    // Request encoding
    // --------------------

    // Command presented on a request port each cycle
    typedef enum logic [1:0] {
        RW_IDLE  = 2'b00,
        RW_READ  = 2'b01,
        RW_WRITE = 2'b10
    } rw_cmd_e;

    // Request bundle seen by the memory
    // Reads return data one cycle later, writes take data in the same cycle
    typedef struct packed {
        rw_cmd_e                       rd_wr_en;
        logic [ABR_MEM_ADDR_WIDTH-1:0] addr;
    } mem_if_t;

endpackage

// ==== src/dcmp_collect.sv ====
module dcmp_collect (
    input  logic                                          clk,
    input  logic                                          reset_n,
    input  logic                                          zeroize,
    input  decompose_defines_pkg::dcmp_lane_out_t [decompose_defines_pkg::DCMP_LANES-1:0] lane_out,
    output logic [abr_params_pkg::ABR_MEM_DATA_WIDTH-1:0] mem_wr_data,
    output logic                                          r1_valid,
    output logic [15:0]                                   r1_data
);

    localparam int SLOT  = decompose_defines_pkg::DCMP_COEFF_SLOT;
    localparam int R1W   = decompose_defines_pkg::DCMP_R1_WIDTH;
    localparam int LANES = decompose_defines_pkg::DCMP_LANES;

    logic                                          lanes_valid;
    logic [abr_params_pkg::ABR_MEM_DATA_WIDTH-1:0] r0_word;
    logic [LANES*R1W-1:0]                          r1_word;

    // Lanes run in lockstep
    assign lanes_valid = lane_out[0].valid;

    // --------------------
    // Word packing
    // --------------------

    always_comb begin
        r0_word = '0;
        r1_word = '0;
        for (int i = 0; i < LANES; i++) begin
            r0_word[i*SLOT +: SLOT] = {1'b0, lane_out[i].r0};
            r1_word[i*R1W +: R1W]   = lane_out[i].r1;
        end
    end

    always_ff @(posedge clk) begin
        if (lanes_valid) begin
            mem_wr_data <= r0_word;
            r1_data     <= r1_word;
        end
    end

    // Lines up with the write strobe from the controller
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r1_valid <= 1'b0;
        end else if (zeroize) begin
            r1_valid <= 1'b0;
        end else begin
            r1_valid <= lanes_valid;
        end
    end

endmodule

// ==== src/dcmp_feed.sv ====
module dcmp_feed (
    input  logic                                          clk,
    input  logic                                          reset_n,
    input  logic                                          zeroize,
    input  logic                                          mod_enable,
    input  logic [abr_params_pkg::ABR_MEM_DATA_WIDTH-1:0] mem_rd_data,
    output decompose_defines_pkg::dcmp_lane_in_t [decompose_defines_pkg::DCMP_LANES-1:0] lane_in
);

    localparam int SLOT = decompose_defines_pkg::DCMP_COEFF_SLOT;
    localparam int CW   = decompose_defines_pkg::DCMP_COEFF_WIDTH;

    logic                                          rd_valid_d;
    logic                                          word_valid;
    logic [abr_params_pkg::ABR_MEM_DATA_WIDTH-1:0] word_q;

    // Memory answers one cycle after the strobe, so the strobe trails it here
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_valid_d <= 1'b0;
            word_valid <= 1'b0;
        end else if (zeroize) begin
            rd_valid_d <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            rd_valid_d <= mod_enable;
            word_valid <= rd_valid_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid_d) begin
            word_q <= mem_rd_data;
        end
    end

    // Slot top bits carry nothing
    always_comb begin
        for (int i = 0; i < decompose_defines_pkg::DCMP_LANES; i++) begin
            lane_in[i].valid = word_valid;
            lane_in[i].coeff = word_q[i*SLOT +: CW];
        end
    end

endmodule

// ==== src/decompose_ctrl.sv ====
module decompose_ctrl (
    input  logic                                         clk,
    input  logic                                         reset_n,
    input  logic                                         zeroize,
    input  logic                                         decompose_enable,
    input  logic [abr_params_pkg::ABR_MEM_ADDR_WIDTH-1:0] src_base_addr,
    input  logic [abr_params_pkg::ABR_MEM_ADDR_WIDTH-1:0] dest_base_addr,
    input  logic                                         r0_ready,
    output abr_params_pkg::mem_if_t                      mem_rd_req,
    output abr_params_pkg::mem_if_t                      mem_wr_req,
    output logic                                         mod_enable,
    output logic                                         decompose_done
);

    localparam int AW = abr_params_pkg::ABR_MEM_ADDR_WIDTH;

    logic [AW-1:0] rd_addr;
    logic [AW-1:0] wr_addr;
    logic [AW-1:0] rd_last_addr;
    logic [AW-1:0] wr_last_addr;
    logic          rd_last;
    logic          wr_last;
    logic          rd_busy;

    decompose_defines_pkg::dcmp_read_state_e  rd_state;
    decompose_defines_pkg::dcmp_read_state_e  rd_state_nxt;
    decompose_defines_pkg::dcmp_write_state_e wr_state;
    decompose_defines_pkg::dcmp_write_state_e wr_state_nxt;

    // --------------------
    // Last-address detection
    // --------------------

    assign rd_last_addr = src_base_addr + AW'(decompose_defines_pkg::DCMP_WORDS - 1);
    assign wr_last_addr = dest_base_addr + AW'(decompose_defines_pkg::DCMP_WORDS - 1);
    assign rd_last      = (rd_addr == rd_last_addr);
    assign wr_last      = (wr_addr == wr_last_addr);

    assign rd_busy        = (rd_state == decompose_defines_pkg::DCMP_RD_MEM);
    assign decompose_done = (rd_state == decompose_defines_pkg::DCMP_RD_IDLE) &&
                            (wr_state == decompose_defines_pkg::DCMP_WR_IDLE);

    // --------------------
    // Read side
    // --------------------

    // Start only when the whole job has drained, otherwise the enable is dropped
    always_comb begin
        rd_state_nxt = rd_state;
        case (rd_state)
            decompose_defines_pkg::DCMP_RD_IDLE: begin
                if (decompose_enable && decompose_done) begin
                    rd_state_nxt = decompose_defines_pkg::DCMP_RD_MEM;
                end
            end
            decompose_defines_pkg::DCMP_RD_MEM: begin
                if (rd_last) begin
                    rd_state_nxt = decompose_defines_pkg::DCMP_RD_IDLE;
                end
            end
            default: rd_state_nxt = decompose_defines_pkg::DCMP_RD_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_state <= decompose_defines_pkg::DCMP_RD_IDLE;
            rd_addr  <= '0;
        end else if (zeroize) begin
            rd_state <= decompose_defines_pkg::DCMP_RD_IDLE;
            rd_addr  <= '0;
        end else begin
            rd_state <= rd_state_nxt;
            // Idle keeps the base loaded so the first read needs no extra cycle
            if (!rd_busy) begin
                rd_addr <= src_base_addr;
            end else begin
                rd_addr <= rd_addr + AW'(1);
            end
        end
    end

    // --------------------
    // Write side
    // --------------------

    // First lane output while reads run marks the head of the result stream
    always_comb begin
        wr_state_nxt = wr_state;
        case (wr_state)
            decompose_defines_pkg::DCMP_WR_IDLE: begin
                if (rd_busy && r0_ready) begin
                    wr_state_nxt = decompose_defines_pkg::DCMP_WR_MEM;
                end
            end
            decompose_defines_pkg::DCMP_WR_MEM: begin
                if (wr_last) begin
                    wr_state_nxt = decompose_defines_pkg::DCMP_WR_IDLE;
                end
            end
            default: wr_state_nxt = decompose_defines_pkg::DCMP_WR_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_state <= decompose_defines_pkg::DCMP_WR_IDLE;
            wr_addr  <= '0;
        end else if (zeroize) begin
            wr_state <= decompose_defines_pkg::DCMP_WR_IDLE;
            wr_addr  <= '0;
        end else begin
            wr_state <= wr_state_nxt;
            if (wr_state == decompose_defines_pkg::DCMP_WR_IDLE) begin
                wr_addr <= dest_base_addr;
            end else begin
                wr_addr <= wr_addr + AW'(1);
            end
        end
    end

    // --------------------
    // Request outputs
    // --------------------

    assign mod_enable = rd_busy;

    always_comb begin
        mem_rd_req.rd_wr_en = rd_busy ? abr_params_pkg::RW_READ : abr_params_pkg::RW_IDLE;
        mem_rd_req.addr     = rd_addr;
        mem_wr_req.rd_wr_en = (wr_state == decompose_defines_pkg::DCMP_WR_MEM) ?
                              abr_params_pkg::RW_WRITE : abr_params_pkg::RW_IDLE;
        mem_wr_req.addr     = wr_addr;
    end

endmodule

// ==== src/decompose_defines_pkg.sv ====
package decompose_defines_pkg;

    // --------------------
    // Ring parameters
    // --------------------

    localparam int DILITHIUM_Q = 8380417;
    localparam int DILITHIUM_N = 256;
    localparam int DILITHIUM_K = 8;

    // gamma2 = (q-1)/32, decompose splits on multiples of 2*gamma2
    localparam int DCMP_GAMMA2     = 261888;
    localparam int DCMP_TWO_GAMMA2 = 2 * DCMP_GAMMA2;

    // --------------------
    // Word layout
    // --------------------

    localparam int DCMP_LANES       = 4;
    localparam int DCMP_WORDS       = DILITHIUM_K * DILITHIUM_N / DCMP_LANES;
    localparam int DCMP_COEFF_WIDTH = 23;
    localparam int DCMP_COEFF_SLOT  = 24;
    localparam int DCMP_R1_WIDTH    = 4;

    // Rounded high part reaches this value only for r >= q - gamma2
    localparam int DCMP_HI_WRAP = (DILITHIUM_Q - 1) / DCMP_TWO_GAMMA2;

    // Division by 2*gamma2 = 512 * 1023
    // floor(y / 1023) == ((y + 1) * 1025) >> 20 for the y range seen here
    localparam int DCMP_PRE_SHIFT   = 9;
    localparam int DCMP_RECIP_MULT  = 1025;
    localparam int DCMP_RECIP_SHIFT = 20;

    // --------------------
    // FSM states
    // --------------------

    typedef enum logic {
        DCMP_RD_IDLE = 1'b0,
        DCMP_RD_MEM  = 1'b1
    } dcmp_read_state_e;

    typedef enum logic {
        DCMP_WR_IDLE = 1'b0,
        DCMP_WR_MEM  = 1'b1
    } dcmp_write_state_e;

    // --------------------
    // Lane bundles
    // --------------------

    typedef struct packed {
        logic                        valid;
        logic [DCMP_COEFF_WIDTH-1:0] coeff;
    } dcmp_lane_in_t;

    typedef struct packed {
        logic                        valid;
        logic [DCMP_R1_WIDTH-1:0]    r1;
        logic [DCMP_COEFF_WIDTH-1:0] r0;
    } dcmp_lane_out_t;

endpackage

// ==== src/decompose_lane.sv ====
module decompose_lane (
    input  logic                                  clk,
    input  logic                                  reset_n,
    input  logic                                  zeroize,
    input  decompose_defines_pkg::dcmp_lane_in_t  lane_in,
    output decompose_defines_pkg::dcmp_lane_out_t lane_out
);

    localparam int CW  = decompose_defines_pkg::DCMP_COEFF_WIDTH;
    localparam int R1W = decompose_defines_pkg::DCMP_R1_WIDTH;
    localparam int SW  = CW + 1;
    localparam int YW  = SW - decompose_defines_pkg::DCMP_PRE_SHIFT;
    localparam int PW  = decompose_defines_pkg::DCMP_RECIP_SHIFT + R1W + 1;

    // Stage 1 signals
    logic [SW-1:0]    round_sum;
    logic [YW-1:0]    sum_hi;
    logic [PW-1:0]    recip_prod;
    logic             s1_valid;
    logic [CW-1:0]    s1_coeff;
    logic [R1W:0]     s1_hi;

    // Stage 2 signals
    logic [CW-1:0]    hi_mult;
    logic [SW-1:0]    r0_centered;
    logic [SW-1:0]    r0_adj;
    logic [SW-1:0]    r0_mod;
    logic             wrap;
    logic             out_valid;
    logic [R1W-1:0]   out_r1;
    logic [CW-1:0]    out_r0;

    // --------------------
    // Stage 1
    // --------------------

    // hi = floor((r + gamma2 - 1) / (2*gamma2)), so r - hi*2*gamma2 lies in (-gamma2, gamma2]
    assign round_sum  = {1'b0, lane_in.coeff} + SW'(decompose_defines_pkg::DCMP_GAMMA2 - 1);
    assign sum_hi     = round_sum[SW-1:decompose_defines_pkg::DCMP_PRE_SHIFT];
    assign recip_prod = (PW'(sum_hi) + PW'(1)) * PW'(decompose_defines_pkg::DCMP_RECIP_MULT);

    always_ff @(posedge clk) begin
        s1_coeff <= lane_in.coeff;
        s1_hi    <= recip_prod[PW-1:decompose_defines_pkg::DCMP_RECIP_SHIFT];
    end

    // --------------------
    // Stage 2
    // --------------------

    assign hi_mult     = CW'(s1_hi) * CW'(decompose_defines_pkg::DCMP_TWO_GAMMA2);
    assign r0_centered = {1'b0, s1_coeff} - {1'b0, hi_mult};

    // r - r0 == q-1 exactly when hi hits the top value
    assign wrap   = (s1_hi == (R1W+1)'(decompose_defines_pkg::DCMP_HI_WRAP));
    assign r0_adj = r0_centered - SW'(wrap);
    assign r0_mod = r0_adj[SW-1] ? r0_adj + SW'(decompose_defines_pkg::DILITHIUM_Q) : r0_adj;

    always_ff @(posedge clk) begin
        out_r1 <= wrap ? '0 : s1_hi[R1W-1:0];
        out_r0 <= r0_mod[CW-1:0];
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else if (zeroize) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= lane_in.valid;
            out_valid <= s1_valid;
        end
    end

    assign lane_out.valid = out_valid;
    assign lane_out.r1    = out_r1;
    assign lane_out.r0    = out_r0;

endmodule

// ==== src/decompose_top.sv ====
module decompose_top (
    input  logic                                          clk,
    input  logic                                          reset_n,
    input  logic                                          zeroize,
    input  logic                                          decompose_enable,
    input  logic [abr_params_pkg::ABR_MEM_ADDR_WIDTH-1:0] src_base_addr,
    input  logic [abr_params_pkg::ABR_MEM_ADDR_WIDTH-1:0] dest_base_addr,
    output abr_params_pkg::mem_if_t                       mem_rd_req,
    input  logic [abr_params_pkg::ABR_MEM_DATA_WIDTH-1:0] mem_rd_data,
    output abr_params_pkg::mem_if_t                       mem_wr_req,
    output logic [abr_params_pkg::ABR_MEM_DATA_WIDTH-1:0] mem_wr_data,
    output logic                                          r1_valid,
    output logic [15:0]                                   r1_data,
    output logic                                          decompose_done
);

    logic mod_enable;

    decompose_defines_pkg::dcmp_lane_in_t  [decompose_defines_pkg::DCMP_LANES-1:0] lane_in;
    decompose_defines_pkg::dcmp_lane_out_t [decompose_defines_pkg::DCMP_LANES-1:0] lane_out;

    decompose_ctrl u_ctrl (
        .clk              (clk),
        .reset_n          (reset_n),
        .zeroize          (zeroize),
        .decompose_enable (decompose_enable),
        .src_base_addr    (src_base_addr),
        .dest_base_addr   (dest_base_addr),
        .r0_ready         (lane_out[0].valid),
        .mem_rd_req       (mem_rd_req),
        .mem_wr_req       (mem_wr_req),
        .mod_enable       (mod_enable),
        .decompose_done   (decompose_done)
    );

    dcmp_feed u_feed (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize     (zeroize),
        .mod_enable  (mod_enable),
        .mem_rd_data (mem_rd_data),
        .lane_in     (lane_in)
    );

    // One lane per coefficient slot
    for (genvar g = 0; g < decompose_defines_pkg::DCMP_LANES; g++) begin : g_lane
        decompose_lane u_lane (
            .clk      (clk),
            .reset_n  (reset_n),
            .zeroize  (zeroize),
            .lane_in  (lane_in[g]),
            .lane_out (lane_out[g])
        );
    end

    dcmp_collect u_collect (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize     (zeroize),
        .lane_out    (lane_out),
        .mem_wr_data (mem_wr_data),
        .r1_valid    (r1_valid),
        .r1_data     (r1_data)
    );

endmodule

// ==== verif/decompose_assertions.sv ====
module decompose_assertions (
    input logic                    clk,
    input logic                    reset_n,
    input logic                    zeroize,
    input abr_params_pkg::mem_if_t mem_rd_req,
    input abr_params_pkg::mem_if_t mem_wr_req,
    input logic                    r1_valid,
    input logic                    decompose_done
);

    int   fail_count = 0;
    logic rd_active;
    logic wr_active;

    assign rd_active = (mem_rd_req.rd_wr_en == abr_params_pkg::RW_READ);
    assign wr_active = (mem_wr_req.rd_wr_en == abr_params_pkg::RW_WRITE);

    // Both request ports stay idle while reset is held
    reset_idle: assert property (@(posedge clk)
        !reset_n |-> (mem_rd_req.rd_wr_en == abr_params_pkg::RW_IDLE &&
                      mem_wr_req.rd_wr_en == abr_params_pkg::RW_IDLE))
    else begin
        fail_count++;
        $error("Memory request active during reset");
    end

    // Back-to-back reads walk the source block one word at a time
    read_step: assert property (@(posedge clk) disable iff (!reset_n)
        (rd_active && $past(rd_active)) |-> (mem_rd_req.addr == $past(mem_rd_req.addr) + 15'd1))
    else begin
        fail_count++;
        $error("Read address did not advance by one");
    end

    r1_with_write: assert property (@(posedge clk) disable iff (!reset_n)
        r1_valid == wr_active)
    else begin
        fail_count++;
        $error("r1_valid and write request out of step");
    end

    // Job end follows the final write, or a zeroize that cut the job short
    done_after_write: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(decompose_done) |-> ($past(wr_active) || $past(zeroize)))
    else begin
        fail_count++;
        $error("decompose_done rose without a preceding write or zeroize");
    end

endmodule

// ==== verif/decompose_tb.sv ====
module decompose_tb;

    // Expected result of one source word, due at a given cycle
    typedef struct packed {
        logic [31:0] due;
        logic [14:0] addr;
        logic [95:0] r0;
        logic [15:0] r1;
    } expect_t;

    logic                    clk;
    logic                    reset_n;
    logic                    zeroize;
    logic                    decompose_enable;
    logic [14:0]             src_base_addr;
    logic [14:0]             dest_base_addr;
    abr_params_pkg::mem_if_t mem_rd_req;
    logic [95:0]             mem_rd_data = '0;
    abr_params_pkg::mem_if_t mem_wr_req;
    logic [95:0]             mem_wr_data;
    logic                    r1_valid;
    logic [15:0]             r1_data;
    logic                    decompose_done;

    logic [95:0] mem [0:1023];
    logic [9:0]  rd_pend_addr = '0;
    expect_t     exp_q[$];
    integer      seed;
    int          errors;
    int          cyc;
    int          rd_count;
    int          wr_count;
    int          last_wr_cyc;
    logic        done_q;
    logic        aborted;
    logic        timed_out;

    decompose_top u_decompose_top (.*);

    bind decompose_top decompose_assertions u_assertions (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // --------------------
    // Memory model
    // --------------------

    // Read data shows up one cycle after the request, writes land the same cycle
    always @(negedge clk) begin
        mem_rd_data = mem[rd_pend_addr];
        rd_pend_addr = mem_rd_req.addr[9:0];
        if (mem_wr_req.rd_wr_en == abr_params_pkg::RW_WRITE) begin
            mem[mem_wr_req.addr[9:0]] = mem_wr_data;
        end
    end

    // --------------------
    // Reference and checks
    // --------------------

    // Returns {r1, r0} with r0 stored modulo q
    function automatic logic [26:0] decompose_ref(input logic [22:0] r);
        int r0;
        int r1;
        r0 = int'(r) % decompose_defines_pkg::DCMP_TWO_GAMMA2;
        if (r0 > decompose_defines_pkg::DCMP_GAMMA2) begin
            r0 = r0 - decompose_defines_pkg::DCMP_TWO_GAMMA2;
        end
        if (int'(r) - r0 == decompose_defines_pkg::DILITHIUM_Q - 1) begin
            r1 = 0;
            r0 = r0 - 1;
        end else begin
            r1 = (int'(r) - r0) / decompose_defines_pkg::DCMP_TWO_GAMMA2;
        end
        if (r0 < 0) begin
            r0 = r0 + decompose_defines_pkg::DILITHIUM_Q;
        end
        return {4'(r1), 23'(r0)};
    endfunction

    task automatic check_value(input string name, input logic [95:0] got, input logic [95:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    always @(negedge clk) begin : compare
        expect_t     e;
        logic [26:0] ref_val;
        logic [14:0] src_addr;
        if (reset_n) begin
            if (mem_rd_req.rd_wr_en == abr_params_pkg::RW_READ) begin
                src_addr = src_base_addr + 15'(rd_count);
                check_value("mem_rd_req.addr", 96'(mem_rd_req.addr), 96'(src_addr));
                e.due  = 32'(cyc + 5);
                e.addr = dest_base_addr + 15'(rd_count);
                for (int i = 0; i < 4; i++) begin
                    ref_val = decompose_ref(mem[src_addr[9:0]][i*24 +: 23]);
                    e.r0[i*24 +: 24] = {1'b0, ref_val[22:0]};
                    e.r1[i*4 +: 4]   = ref_val[26:23];
                end
                exp_q.push_back(e);
                rd_count++;
            end
            if (mem_wr_req.rd_wr_en == abr_params_pkg::RW_WRITE || r1_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Write or r1 strobe at %0t with no outstanding read", $time);
                end else begin
                    e = exp_q.pop_front();
                    check_value("write cycle", 96'(cyc), 96'(e.due));
                    check_value("mem_wr_req.rd_wr_en", 96'(mem_wr_req.rd_wr_en),
                                96'(abr_params_pkg::RW_WRITE));
                    check_value("r1_valid", 96'(r1_valid), 96'(1));
                    check_value("mem_wr_req.addr", 96'(mem_wr_req.addr), 96'(e.addr));
                    check_value("mem_wr_data", mem_wr_data, e.r0);
                    check_value("r1_data", 96'(r1_data), 96'(e.r1));
                end
                wr_count++;
                last_wr_cyc = cyc;
            end
            if (decompose_done && !done_q && !aborted) begin
                check_value("decompose_done rise cycle", 96'(cyc), 96'(last_wr_cyc + 1));
            end
        end
        done_q = decompose_done;
        cyc++;
    end

    // --------------------
    // Stimulus
    // --------------------

    task automatic fill_memory();
        logic [31:0] u;
        int          idx;
        int          v;
        idx = 0;
        for (int a = 0; a < 1024; a++) begin
            for (int s = 0; s < 4; s++) begin
                u = $random(seed);
                mem[10'(a)][s*24 +: 24] = {1'b0, 23'(u % 32'(decompose_defines_pkg::DILITHIUM_Q))};
            end
        end
        // Multiples of 2*gamma2 with neighbours, rounding edges and the wrap region
        for (int k = 0; k <= 16; k++) begin
            for (int d = 0; d < 6; d++) begin
                v = k * decompose_defines_pkg::DCMP_TWO_GAMMA2 +
                    ((d < 3) ? d - 1 : decompose_defines_pkg::DCMP_GAMMA2 + d - 3);
                if (v >= 0 && v < decompose_defines_pkg::DILITHIUM_Q) begin
                    mem[10'(idx / 4)][(idx % 4)*24 +: 24] = {1'b0, 23'(v)};
                    idx++;
                end
            end
        end
    endtask

    task automatic check_idle();
        check_value("mem_rd_req.rd_wr_en", 96'(mem_rd_req.rd_wr_en), 96'(abr_params_pkg::RW_IDLE));
        check_value("mem_wr_req.rd_wr_en", 96'(mem_wr_req.rd_wr_en), 96'(abr_params_pkg::RW_IDLE));
        check_value("r1_valid", 96'(r1_valid), 96'(0));
        check_value("decompose_done", 96'(decompose_done), 96'(1));
    endtask

    task automatic start_job(input logic [14:0] src, input logic [14:0] dest);
        src_base_addr    = src;
        dest_base_addr   = dest;
        rd_count         = 0;
        wr_count         = 0;
        aborted          = 1'b0;
        decompose_enable = 1'b1;
        @(negedge clk);
        decompose_enable = 1'b0;
        check_value("decompose_done", 96'(decompose_done), 96'(0));
        check_value("mem_rd_req.rd_wr_en", 96'(mem_rd_req.rd_wr_en), 96'(abr_params_pkg::RW_READ));
    endtask

    task automatic wait_reads_idle(input int max_cycles);
        int n;
        n = 0;
        while (mem_rd_req.rd_wr_en == abr_params_pkg::RW_READ && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (mem_rd_req.rd_wr_en == abr_params_pkg::RW_READ) begin
            timed_out = 1'b1;
            $display("Timeout: reads did not stop within %0d cycles", max_cycles);
        end
    endtask

    task automatic wait_done(input int max_cycles);
        int n;
        n = 0;
        while (!decompose_done && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (!decompose_done) begin
            timed_out = 1'b1;
            $display("Timeout: decompose_done did not rise within %0d cycles", max_cycles);
        end
    endtask

    task automatic check_job_counts();
        check_value("read count", 96'(rd_count), 96'(decompose_defines_pkg::DCMP_WORDS));
        check_value("write count", 96'(wr_count), 96'(decompose_defines_pkg::DCMP_WORDS));
        check_value("pending results", 96'(exp_q.size()), 96'(0));
    endtask

    task automatic run_tests();
        repeat (3) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        check_idle();
        // Full job with stray enables while busy
        start_job(15'h0000, 15'h0200);
        repeat (40) @(negedge clk);
        decompose_enable = 1'b1;
        @(negedge clk);
        decompose_enable = 1'b0;
        // Reads are over but the last results are still being written
        wait_reads_idle(600);
        if (timed_out) return;
        check_value("decompose_done", 96'(decompose_done), 96'(0));
        decompose_enable = 1'b1;
        @(negedge clk);
        decompose_enable = 1'b0;
        wait_done(700);
        if (timed_out) return;
        check_job_counts();
        // Zeroize part way through a job
        start_job(15'h1200, 15'h3000);
        repeat (120) @(negedge clk);
        zeroize = 1'b1;
        aborted = 1'b1;
        @(negedge clk);
        zeroize = 1'b0;
        check_idle();
        exp_q.delete();
        @(negedge clk);
        start_job(15'h2000, 15'h0600);
        wait_done(700);
        if (timed_out) return;
        check_job_counts();
    endtask

    initial begin
        seed             = 32'hd2ff2b1d;
        reset_n          = 1'b0;
        zeroize          = 1'b0;
        decompose_enable = 1'b0;
        src_base_addr    = '0;
        dest_base_addr   = '0;
        errors           = 0;
        cyc              = 0;
        rd_count         = 0;
        wr_count         = 0;
        last_wr_cyc      = 0;
        done_q           = 1'b1;
        aborted          = 1'b0;
        timed_out        = 1'b0;
        fill_memory();
        run_tests();
        $display("Summary: %0d check errors, %0d assertion failures, %0d timeouts",
                 errors, u_decompose_top.u_assertions.fail_count, timed_out);
        if (errors == 0 && !timed_out && u_decompose_top.u_assertions.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
